// File: scrmbl_config.svh
`ifndef SCRMBL_CONFIG_SVH
`define SCRMBL_CONFIG_SVH

// data block width of the PRESENT cipher
`define SCRMBL_BLOCK_W 64

// key width, PRESENT-128 variant
`define SCRMBL_KEY_W 128

// full PRESENT round count, the last round also carries the whitening key
`define SCRMBL_NUM_ROUNDS 31

// number of fixed scrambling keys selectable through sel_i
`define SCRMBL_NUM_KEYS 3

// key 0 is all zeros so the published PRESENT-128 vector can be checked against it
`define SCRMBL_KEY0 128'h0000_0000_0000_0000_0000_0000_0000_0000
`define SCRMBL_KEY1 128'h3ba7_0c5e_91d4_f286_6a1b_e94c_07d3_58af
`define SCRMBL_KEY2 128'hc46e_12f9_8b3a_d057_e2c8_6f14_a9b5_3d70

`endif

// File: scrmbl_pkg.sv
`include "scrmbl_config.svh"

package scrmbl_pkg;

  typedef logic [`SCRMBL_BLOCK_W-1:0] block_t;
  typedef logic [`SCRMBL_KEY_W-1:0]   key_t;
  // round index as used by the key schedule, runs from 1 up to 31
  typedef logic [4:0]                 round_idx_t;
  typedef logic [1:0]                 key_sel_t;
  typedef logic [4:0]                 round_cnt_t;

  typedef enum logic {
    CmdDecrypt = 1'b0,
    CmdEncrypt = 1'b1
  } cmd_e;

  // sparse encoding, every pair of states differs in at least 5 bits
  typedef enum logic [8:0] {
    IdleSt    = 9'b100011001,
    DecryptSt = 9'b101101111,
    EncryptSt = 9'b010010111,
    ErrorSt   = 9'b011111000
  } state_e;

  typedef enum logic [1:0] {
    DataSelInput = 2'b00,
    DataSelEnc   = 2'b01,
    DataSelDec   = 2'b10
  } data_sel_e;

  typedef enum logic [2:0] {
    KeySrcEncOut  = 3'b000,
    KeySrcDecOut  = 3'b001,
    KeySrcEncInit = 3'b010,
    KeySrcDecInit = 3'b011
  } key_sel_src_e;

  // 4-bit PRESENT S-box and its inverse, entry n sits in nibble n
  localparam logic [15:0][3:0] sbox_lut     = 64'h21748fe3da09b65c;
  localparam logic [15:0][3:0] inv_sbox_lut = 64'ha970364bd21c8fe5;

  function automatic block_t present_sbox(block_t data_in);
    block_t data_out;
    for (int i = 0; i < `SCRMBL_BLOCK_W / 4; i++) begin
      data_out[4*i +: 4] = sbox_lut[data_in[4*i +: 4]];
    end
    return data_out;
  endfunction

  function automatic block_t present_inv_sbox(block_t data_in);
    block_t data_out;
    for (int i = 0; i < `SCRMBL_BLOCK_W / 4; i++) begin
      data_out[4*i +: 4] = inv_sbox_lut[data_in[4*i +: 4]];
    end
    return data_out;
  endfunction

  // forward schedule: rotate left by 61, S-box on the top two nibbles, mix in the counter
  function automatic key_t present_key_update(key_t key_in, round_idx_t idx);
    key_t key_out;
    key_out          = {key_in[66:0], key_in[127:67]};
    key_out[127:124] = sbox_lut[key_out[127:124]];
    key_out[123:120] = sbox_lut[key_out[123:120]];
    key_out[66:62]   = key_out[66:62] ^ idx;
    return key_out;
  endfunction

  // inverse schedule: the same three steps undone in reverse order
  function automatic key_t present_key_revert(key_t key_in, round_idx_t idx);
    key_t key_out;
    key_out          = key_in;
    key_out[66:62]   = key_out[66:62] ^ idx;
    key_out[127:124] = inv_sbox_lut[key_out[127:124]];
    key_out[123:120] = inv_sbox_lut[key_out[123:120]];
    key_out          = {key_out[60:0], key_out[127:61]};
    return key_out;
  endfunction

endpackage

// File: scrmbl_key_lut.sv
`timescale 1ns/1ns
`include "scrmbl_config.svh"

module scrmbl_key_lut (
  input  scrmbl_pkg::key_sel_t sel_i,
  input  logic                 key_load_i,
  output scrmbl_pkg::key_t     enc_key_o,
  output scrmbl_pkg::key_t     dec_key_o
);

  // tables are padded to a power of two so every sel_i value maps to a defined entry
  scrmbl_pkg::key_t enc_key_lut [4];
  scrmbl_pkg::key_t dec_key_lut [4];

  ////////////////////
  // key tables
  ////////////////////

  always_comb begin : p_key_tables
    scrmbl_pkg::key_t key_step;
    enc_key_lut[0] = `SCRMBL_KEY0;
    enc_key_lut[1] = `SCRMBL_KEY1;
    enc_key_lut[2] = `SCRMBL_KEY2;
    enc_key_lut[3] = '0;
    // decryption starts from the key the forward schedule ends with,
    // so each key is stepped through all rounds here with constant inputs only
    for (int k = 0; k < 4; k++) begin
      key_step = enc_key_lut[k];
      for (int r = 1; r <= `SCRMBL_NUM_ROUNDS; r++) begin
        key_step = scrmbl_pkg::present_key_update(key_step, scrmbl_pkg::round_idx_t'(r));
      end
      dec_key_lut[k] = key_step;
    end
  end

  assign enc_key_o = enc_key_lut[sel_i];
  assign dec_key_o = dec_key_lut[sel_i];

  // the controller only ever loads one of the real keys, never the padding entry
  always_comb begin : p_sel_check
    if (key_load_i) begin
      assert (sel_i < scrmbl_pkg::key_sel_t'(`SCRMBL_NUM_KEYS))
        else $error("key index %0d loaded but only %0d keys exist", sel_i, `SCRMBL_NUM_KEYS);
    end
  end

endmodule

// File: present_enc_round.sv
`timescale 1ns/1ns
`include "scrmbl_config.svh"

module present_enc_round (
  input  scrmbl_pkg::block_t     data_i,
  input  scrmbl_pkg::key_t       key_i,
  input  scrmbl_pkg::round_idx_t idx_i,
  output scrmbl_pkg::block_t     data_o,
  output scrmbl_pkg::key_t       key_o,
  output scrmbl_pkg::round_idx_t idx_o
);

  scrmbl_pkg::block_t keyed;
  scrmbl_pkg::block_t subst;
  scrmbl_pkg::block_t permuted;
  scrmbl_pkg::key_t   key_next;

  always_comb begin : p_round
    // round key is the top half of the current key register
    keyed = data_i ^ key_i[`SCRMBL_KEY_W-1 -: `SCRMBL_BLOCK_W];
    subst = scrmbl_pkg::present_sbox(keyed);

    // bit permutation, bit i moves to 16*i mod 63 and bit 63 stays in place
    for (int i = 0; i < `SCRMBL_BLOCK_W - 1; i++) begin
      permuted[(i * 16) % 63] = subst[i];
    end
    permuted[`SCRMBL_BLOCK_W-1] = subst[`SCRMBL_BLOCK_W-1];

    key_next = scrmbl_pkg::present_key_update(key_i, idx_i);

    // after the last round the freshly updated key is added once more as whitening
    data_o = permuted;
    if (idx_i == scrmbl_pkg::round_idx_t'(`SCRMBL_NUM_ROUNDS)) begin
      data_o = permuted ^ key_next[`SCRMBL_KEY_W-1 -: `SCRMBL_BLOCK_W];
    end
  end

  assign key_o = key_next;

  // wraps to zero after round 31, which the datapath never uses again
  assign idx_o = idx_i + scrmbl_pkg::round_idx_t'(1);

endmodule

// File: present_dec_round.sv
`timescale 1ns/1ns
`include "scrmbl_config.svh"

module present_dec_round (
  input  scrmbl_pkg::block_t     data_i,
  input  scrmbl_pkg::key_t       key_i,
  input  scrmbl_pkg::round_idx_t idx_i,
  output scrmbl_pkg::block_t     data_o,
  output scrmbl_pkg::key_t       key_o,
  output scrmbl_pkg::round_idx_t idx_o
);

  scrmbl_pkg::block_t unwhitened;
  scrmbl_pkg::block_t unpermuted;
  scrmbl_pkg::block_t unsubst;
  scrmbl_pkg::key_t   key_prev;

  always_comb begin : p_round
    // the first decryption step sees idx 31 and strips the whitening key,
    // which is exactly the key the table handed in
    unwhitened = data_i;
    if (idx_i == scrmbl_pkg::round_idx_t'(`SCRMBL_NUM_ROUNDS)) begin
      unwhitened = data_i ^ key_i[`SCRMBL_KEY_W-1 -: `SCRMBL_BLOCK_W];
    end

    // inverse permutation, bit i is fetched back from position 16*i mod 63
    for (int i = 0; i < `SCRMBL_BLOCK_W - 1; i++) begin
      unpermuted[i] = unwhitened[(i * 16) % 63];
    end
    unpermuted[`SCRMBL_BLOCK_W-1] = unwhitened[`SCRMBL_BLOCK_W-1];

    unsubst = scrmbl_pkg::present_inv_sbox(unpermuted);

    // step the schedule back to the key that was used going into this round
    key_prev = scrmbl_pkg::present_key_revert(key_i, idx_i);

    data_o = unsubst ^ key_prev[`SCRMBL_KEY_W-1 -: `SCRMBL_BLOCK_W];
  end

  assign key_o = key_prev;

  // reaches zero once round 1 is undone
  assign idx_o = idx_i - scrmbl_pkg::round_idx_t'(1);

endmodule

// File: scrmbl_datapath.sv
`timescale 1ns/1ns
`include "scrmbl_config.svh"

module scrmbl_datapath (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  scrmbl_pkg::block_t       data_i,
  input  scrmbl_pkg::key_t         enc_key_i,
  input  scrmbl_pkg::key_t         dec_key_i,
  input  logic                     data_en_i,
  input  logic                     key_en_i,
  input  scrmbl_pkg::data_sel_e    data_sel_i,
  input  scrmbl_pkg::key_sel_src_e key_src_i,
  input  logic                     valid_i,
  output scrmbl_pkg::block_t       data_o
);

  scrmbl_pkg::block_t     data_state_d, data_state_q;
  scrmbl_pkg::key_t       key_state_d, key_state_q;
  scrmbl_pkg::round_idx_t idx_state_d, idx_state_q;

  scrmbl_pkg::block_t     enc_data, dec_data;
  scrmbl_pkg::key_t       enc_key, dec_key;
  scrmbl_pkg::round_idx_t enc_idx, dec_idx;

  ////////////////////
  // input selection
  ////////////////////

  always_comb begin : p_data_mux
    unique case (data_sel_i)
      scrmbl_pkg::DataSelEnc: data_state_d = enc_data;
      scrmbl_pkg::DataSelDec: data_state_d = dec_data;
      default:                data_state_d = data_i;
    endcase
  end

  // the key source also tells where the round index starts from
  always_comb begin : p_key_mux
    unique case (key_src_i)
      scrmbl_pkg::KeySrcEncOut: begin
        key_state_d = enc_key;
        idx_state_d = enc_idx;
      end
      scrmbl_pkg::KeySrcDecOut: begin
        key_state_d = dec_key;
        idx_state_d = dec_idx;
      end
      scrmbl_pkg::KeySrcDecInit: begin
        key_state_d = dec_key_i;
        idx_state_d = scrmbl_pkg::round_idx_t'(`SCRMBL_NUM_ROUNDS);
      end
      default: begin
        key_state_d = enc_key_i;
        idx_state_d = scrmbl_pkg::round_idx_t'(1);
      end
    endcase
  end

  ////////////////////
  // working registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_idx_reg
    if (!rst_ni) begin
      idx_state_q <= '0;
    end else if (key_en_i) begin
      idx_state_q <= idx_state_d;
    end
  end

  always_ff @(posedge clk_i) begin : p_state_regs
    if (data_en_i) begin
      data_state_q <= data_state_d;
    end
    if (key_en_i) begin
      key_state_q <= key_state_d;
    end
  end

  // result is only visible in the cycle of the valid pulse
  assign data_o = valid_i ? data_state_q : '0;

  ////////////////////
  // round instances
  ////////////////////

  present_enc_round i_enc_round (
    .data_i (data_state_q),
    .key_i  (key_state_q),
    .idx_i  (idx_state_q),
    .data_o (enc_data),
    .key_o  (enc_key),
    .idx_o  (enc_idx)
  );

  present_dec_round i_dec_round (
    .data_i (data_state_q),
    .key_i  (key_state_q),
    .idx_i  (idx_state_q),
    .data_o (dec_data),
    .key_o  (dec_key),
    .idx_o  (dec_idx)
  );

  // every round the controller applies works on an index set up by an earlier load
  a_idx_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (key_en_i && ((key_src_i == scrmbl_pkg::KeySrcEncOut) ||
                  (key_src_i == scrmbl_pkg::KeySrcDecOut)))
    |-> ((idx_state_q >= scrmbl_pkg::round_idx_t'(1)) &&
         (idx_state_q <= scrmbl_pkg::round_idx_t'(`SCRMBL_NUM_ROUNDS))))
    else $error("round index %0d out of range", idx_state_q);

endmodule

// File: scrmbl_ctrl.sv
`timescale 1ns/1ns
`include "scrmbl_config.svh"

module scrmbl_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  scrmbl_pkg::cmd_e         cmd_i,
  input  logic                     valid_i,
  input  logic                     escalate_i,
  output logic                     ready_o,
  output logic                     valid_o,
  output logic                     fsm_err_o,
  output logic                     data_en_o,
  output logic                     key_en_o,
  output scrmbl_pkg::data_sel_e    data_sel_o,
  output scrmbl_pkg::key_sel_src_e key_src_o,
  output logic                     key_load_o
);

  // the counter starts at zero on the first round, so the last round sees 30
  localparam scrmbl_pkg::round_cnt_t last_round_cnt =
    scrmbl_pkg::round_cnt_t'(`SCRMBL_NUM_ROUNDS - 1);

  scrmbl_pkg::state_e     state_d, state_q;
  scrmbl_pkg::round_cnt_t cnt_d, cnt_q;
  logic                   valid_d, valid_q;

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin : p_fsm
    state_d    = state_q;
    cnt_d      = cnt_q;
    valid_d    = 1'b0;
    ready_o    = 1'b0;
    fsm_err_o  = 1'b0;
    data_en_o  = 1'b0;
    key_en_o   = 1'b0;
    key_load_o = 1'b0;
    data_sel_o = scrmbl_pkg::DataSelInput;
    key_src_o  = scrmbl_pkg::KeySrcEncInit;

    unique case (state_q)
      // accept a command and load data, initial key and start index in one edge
      scrmbl_pkg::IdleSt: begin
        ready_o = 1'b1;
        cnt_d   = '0;
        if (valid_i) begin
          data_en_o  = 1'b1;
          key_en_o   = 1'b1;
          key_load_o = 1'b1;
          case (cmd_i)
            scrmbl_pkg::CmdEncrypt: begin
              state_d   = scrmbl_pkg::EncryptSt;
              key_src_o = scrmbl_pkg::KeySrcEncInit;
            end
            scrmbl_pkg::CmdDecrypt: begin
              state_d   = scrmbl_pkg::DecryptSt;
              key_src_o = scrmbl_pkg::KeySrcDecInit;
            end
          endcase
        end
      end
      // one decryption round per clock until the count reaches the last round
      scrmbl_pkg::DecryptSt: begin
        data_en_o  = 1'b1;
        key_en_o   = 1'b1;
        data_sel_o = scrmbl_pkg::DataSelDec;
        key_src_o  = scrmbl_pkg::KeySrcDecOut;
        cnt_d      = cnt_q + scrmbl_pkg::round_cnt_t'(1);
        if (cnt_q == last_round_cnt) begin
          state_d = scrmbl_pkg::IdleSt;
          valid_d = 1'b1;
        end
      end
      scrmbl_pkg::EncryptSt: begin
        data_en_o  = 1'b1;
        key_en_o   = 1'b1;
        data_sel_o = scrmbl_pkg::DataSelEnc;
        key_src_o  = scrmbl_pkg::KeySrcEncOut;
        cnt_d      = cnt_q + scrmbl_pkg::round_cnt_t'(1);
        if (cnt_q == last_round_cnt) begin
          state_d = scrmbl_pkg::IdleSt;
          valid_d = 1'b1;
        end
      end
      // terminal, only a reset leaves this state
      scrmbl_pkg::ErrorSt: begin
        fsm_err_o = 1'b1;
      end
      // an encoding outside the four legal states is treated as a fault
      default: begin
        state_d   = scrmbl_pkg::ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // escalation wins over everything and drops a result that would be due now
    if (escalate_i) begin
      state_d = scrmbl_pkg::ErrorSt;
      valid_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q <= scrmbl_pkg::IdleSt;
      cnt_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      valid_q <= valid_d;
    end
  end

  assign valid_o = valid_q;

  // the result pulse always coincides with the return to idle
  a_valid_in_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |-> (state_q == scrmbl_pkg::IdleSt))
    else $error("valid_o high outside of idle");

  a_err_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fsm_err_o |=> fsm_err_o)
    else $error("fsm_err_o dropped before reset");

endmodule

// File: otp_scrmbl.sv
`timescale 1ns/1ns

module otp_scrmbl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  scrmbl_pkg::cmd_e     cmd_i,
  input  scrmbl_pkg::key_sel_t sel_i,
  input  scrmbl_pkg::block_t   data_i,
  input  logic                 valid_i,
  output logic                 ready_o,
  output scrmbl_pkg::block_t   data_o,
  output logic                 valid_o,
  input  logic                 escalate_i,
  output logic                 fsm_err_o
);

  logic                     data_en;
  logic                     key_en;
  logic                     key_load;
  logic                     valid_q;
  scrmbl_pkg::data_sel_e    data_sel;
  scrmbl_pkg::key_sel_src_e key_src;
  scrmbl_pkg::key_t         enc_key;
  scrmbl_pkg::key_t         dec_key;

  // the controller owns all sequencing, the key table and datapath just follow it
  scrmbl_ctrl i_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cmd_i      (cmd_i),
    .valid_i    (valid_i),
    .escalate_i (escalate_i),
    .ready_o    (ready_o),
    .valid_o    (valid_q),
    .fsm_err_o  (fsm_err_o),
    .data_en_o  (data_en),
    .key_en_o   (key_en),
    .data_sel_o (data_sel),
    .key_src_o  (key_src),
    .key_load_o (key_load)
  );

  scrmbl_key_lut i_key_lut (
    .sel_i      (sel_i),
    .key_load_i (key_load),
    .enc_key_o  (enc_key),
    .dec_key_o  (dec_key)
  );

  scrmbl_datapath i_datapath (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .data_i     (data_i),
    .enc_key_i  (enc_key),
    .dec_key_i  (dec_key),
    .data_en_i  (data_en),
    .key_en_i   (key_en),
    .data_sel_i (data_sel),
    .key_src_i  (key_src),
    .valid_i    (valid_q),
    .data_o     (data_o)
  );

  assign valid_o = valid_q;

endmodule

// File: tb_present_model.svh
`ifndef TB_PRESENT_MODEL_SVH
`define TB_PRESENT_MODEL_SVH

`include "scrmbl_config.svh"

////////////////////
// PRESENT-128 model
////////////////////

// standard PRESENT S-box, indexed by the input nibble
localparam logic [3:0] ref_sbox [16] = '{
  4'hc, 4'h5, 4'h6, 4'hb, 4'h9, 4'h0, 4'ha, 4'hd,
  4'h3, 4'he, 4'hf, 4'h8, 4'h4, 4'h7, 4'h1, 4'h2
};

// inverse table, so that ref_inv_sbox[ref_sbox[x]] gives back x
localparam logic [3:0] ref_inv_sbox [16] = '{
  4'h5, 4'he, 4'hf, 4'h8, 4'hc, 4'h1, 4'h2, 4'hd,
  4'hb, 4'h4, 4'h6, 4'h3, 4'h0, 4'h7, 4'h9, 4'ha
};

// substitution layer over all sixteen nibbles of the state
function automatic scrmbl_pkg::block_t ref_sub_layer(scrmbl_pkg::block_t x, bit inverse);
  scrmbl_pkg::block_t y;
  for (int n = 0; n < 16; n++) begin
    if (inverse) begin
      y[4*n +: 4] = ref_inv_sbox[x[4*n +: 4]];
    end else begin
      y[4*n +: 4] = ref_sbox[x[4*n +: 4]];
    end
  end
  return y;
endfunction

// bit i of the state moves to 16 * (i mod 4) + i / 4, which also keeps bit 63 in place
function automatic scrmbl_pkg::block_t ref_perm_layer(scrmbl_pkg::block_t x, bit inverse);
  scrmbl_pkg::block_t y;
  int dst;
  for (int i = 0; i < 64; i++) begin
    dst = 16 * (i % 4) + i / 4;
    if (inverse) begin
      y[i] = x[dst];
    end else begin
      y[dst] = x[i];
    end
  end
  return y;
endfunction

// one step of the 128-bit key schedule with round counter rc
function automatic scrmbl_pkg::key_t ref_key_step(scrmbl_pkg::key_t k, logic [4:0] rc);
  scrmbl_pkg::key_t r;
  // rotate the whole register left by 61 positions
  r = (k << 61) | (k >> 67);
  r[127:124] = ref_sbox[r[127:124]];
  r[123:120] = ref_sbox[r[123:120]];
  r[66:62]   = r[66:62] ^ rc;
  return r;
endfunction

// the three fixed scrambling keys, unused index gives zero
function automatic scrmbl_pkg::key_t ref_key(int sel);
  case (sel)
    0: return `SCRMBL_KEY0;
    1: return `SCRMBL_KEY1;
    2: return `SCRMBL_KEY2;
    default: return '0;
  endcase
endfunction

// 31 full rounds, then the 32nd round key is added on its own
function automatic scrmbl_pkg::block_t ref_encrypt(scrmbl_pkg::block_t pt,
                                                  scrmbl_pkg::key_t key);
  scrmbl_pkg::block_t state;
  scrmbl_pkg::key_t   k;
  state = pt;
  k     = key;
  for (int r = 1; r <= 31; r++) begin
    state = state ^ k[127:64];
    state = ref_sub_layer(state, 1'b0);
    state = ref_perm_layer(state, 1'b0);
    k     = ref_key_step(k, 5'(r));
  end
  return state ^ k[127:64];
endfunction

// all 32 round keys are expanded first and then applied in reverse order
function automatic scrmbl_pkg::block_t ref_decrypt(scrmbl_pkg::block_t ct,
                                                  scrmbl_pkg::key_t key);
  scrmbl_pkg::block_t rk [33];
  scrmbl_pkg::block_t state;
  scrmbl_pkg::key_t   k;
  k     = key;
  rk[1] = k[127:64];
  for (int r = 1; r <= 31; r++) begin
    k         = ref_key_step(k, 5'(r));
    rk[r + 1] = k[127:64];
  end
  state = ct ^ rk[32];
  for (int r = 31; r >= 1; r--) begin
    state = ref_perm_layer(state, 1'b1);
    state = ref_sub_layer(state, 1'b1);
    state = state ^ rk[r];
  end
  return state;
endfunction

`endif

// File: tb_otp_scrmbl.sv
`timescale 1ns/1ns
`include "scrmbl_config.svh"

module tb_otp_scrmbl;

  localparam int clk_period     = 100;
  localparam int drive_delay    = 10;
  localparam int latency        = `SCRMBL_NUM_ROUNDS;
  localparam int result_timeout = 60;
  // one known vector plus 120 round trip, 3 busy, 6 back to back and 2 escalation commands
  localparam int num_cmds       = 132;
  localparam int wd_cycles      = num_cmds * 40 + 200;

  logic                 clk_i;
  logic                 rst_ni;
  scrmbl_pkg::cmd_e     cmd_i;
  scrmbl_pkg::key_sel_t sel_i;
  scrmbl_pkg::block_t   data_i;
  logic                 valid_i;
  logic                 ready_o;
  scrmbl_pkg::block_t   data_o;
  logic                 valid_o;
  logic                 escalate_i;
  logic                 fsm_err_o;

  int seed        = 32'h31818229;
  int error_count = 0;
  int check_count = 0;
  int test_count  = 0;

  `include "tb_present_model.svh"

  otp_scrmbl i_dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cmd_i      (cmd_i),
    .sel_i      (sel_i),
    .data_i     (data_i),
    .valid_i    (valid_i),
    .ready_o    (ready_o),
    .data_o     (data_o),
    .valid_o    (valid_o),
    .escalate_i (escalate_i),
    .fsm_err_o  (fsm_err_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(clk_period / 2) clk_i = ~clk_i;
    end
  end

  // hard limit on run time that is sized from the command count
  initial begin
    #(wd_cycles * clk_period);
    $display("watchdog expired after %0d cycles, the run did not finish", wd_cycles);
    $display("TESTS FAILED");
    $finish;
  end

  ////////////////////
  // checks
  ////////////////////

  task automatic compare_block(input string test, input string what,
                               input scrmbl_pkg::block_t exp, input scrmbl_pkg::block_t act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("[FAIL] %s %s: expected %h, actual %h", test, what, exp, act);
    end
  endtask

  task automatic compare_bit(input string test, input string what,
                             input logic exp, input logic act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("[FAIL] %s %s: expected %b, actual %b", test, what, exp, act);
    end
  endtask

  task automatic compare_count(input string test, input string what,
                               input int exp, input int act);
    check_count++;
    if (exp != act) begin
      error_count++;
      $display("[FAIL] %s %s: expected %0d, actual %0d", test, what, exp, act);
    end
  endtask

  task automatic finish_test(input string test, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
      $display("test %s: ok", test);
    end else begin
      $display("test %s: %0d errors", test, error_count - errors_before);
    end
  endtask

  ////////////////////
  // drivers
  ////////////////////

  // every task starts and ends at the drive point 10 ns after a rising edge
  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (3) @(posedge clk_i);
    #drive_delay;
    rst_ni = 1'b1;
  endtask

  task automatic issue_cmd(input string test, input scrmbl_pkg::cmd_e cmd,
                           input scrmbl_pkg::key_sel_t sel, input scrmbl_pkg::block_t data);
    int waited;
    waited = 0;
    while (!ready_o && waited < result_timeout) begin
      @(posedge clk_i);
      #drive_delay;
      waited++;
    end
    if (!ready_o) begin
      error_count++;
      $display("%s: ready_o stayed low, the command could not be issued", test);
    end
    cmd_i   = cmd;
    sel_i   = sel;
    data_i  = data;
    valid_i = 1'b1;
    @(posedge clk_i);
    #drive_delay;
    valid_i = 1'b0;
  endtask

  // issues one command and waits for its valid pulse while optionally driving junk
  task automatic run_cmd(input string test, input scrmbl_pkg::cmd_e cmd,
                         input scrmbl_pkg::key_sel_t sel, input scrmbl_pkg::block_t data,
                         input bit noise, output scrmbl_pkg::block_t result);
    int edges;
    issue_cmd(test, cmd, sel, data);
    edges = 0;
    while (!valid_o && edges < result_timeout) begin
      compare_block(test, "data_o while busy", '0, data_o);
      if (noise) begin
        valid_i = 1'b1;
        cmd_i   = ($random(seed) % 2 == 0) ? scrmbl_pkg::CmdDecrypt : scrmbl_pkg::CmdEncrypt;
        sel_i   = scrmbl_pkg::key_sel_t'($unsigned($random(seed)) % 3);
        data_i  = {$random(seed), $random(seed)};
      end
      @(posedge clk_i);
      #drive_delay;
      edges++;
    end
    // junk must not become a new command once ready_o is back
    valid_i = 1'b0;
    if (!valid_o) begin
      error_count++;
      $display("%s: no valid_o pulse within %0d cycles of the command", test, result_timeout);
    end
    compare_count(test, "cycles to valid_o", latency, edges);
    compare_bit(test, "ready_o with valid_o", 1'b1, ready_o);
    result = data_o;
  endtask

  task automatic check_error_hold(input string test, input int cycles);
    for (int c = 0; c < cycles; c++) begin
      compare_bit(test, "valid_o in error", 1'b0, valid_o);
      compare_bit(test, "fsm_err_o in error", 1'b1, fsm_err_o);
      compare_bit(test, "ready_o in error", 1'b0, ready_o);
      @(posedge clk_i);
      #drive_delay;
    end
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic test_reset_values();
    int errors_before;
    errors_before = error_count;
    compare_bit("reset_values", "ready_o", 1'b1, ready_o);
    compare_bit("reset_values", "valid_o", 1'b0, valid_o);
    compare_bit("reset_values", "fsm_err_o", 1'b0, fsm_err_o);
    compare_block("reset_values", "data_o", '0, data_o);
    finish_test("reset_values", errors_before);
  endtask

  // published PRESENT-128 vector with an all-zero key and block
  task automatic test_known_vector();
    int errors_before;
    scrmbl_pkg::block_t result;
    errors_before = error_count;
    compare_block("known_vector", "model", 64'h96db702a2e6900af, ref_encrypt('0, ref_key(0)));
    run_cmd("known_vector", scrmbl_pkg::CmdEncrypt, 2'd0, '0, 1'b0, result);
    compare_block("known_vector", "ciphertext", 64'h96db702a2e6900af, result);
    @(posedge clk_i);
    #drive_delay;
    compare_bit("known_vector", "valid_o after pulse", 1'b0, valid_o);
    compare_block("known_vector", "data_o after pulse", '0, data_o);
    finish_test("known_vector", errors_before);
  endtask

  task automatic test_random_roundtrip();
    int errors_before;
    scrmbl_pkg::block_t plain;
    scrmbl_pkg::block_t cipher_exp;
    scrmbl_pkg::block_t cipher;
    scrmbl_pkg::block_t result;
    errors_before = error_count;
    for (int s = 0; s < `SCRMBL_NUM_KEYS; s++) begin
      for (int n = 0; n < 20; n++) begin
        plain      = {$random(seed), $random(seed)};
        cipher_exp = ref_encrypt(plain, ref_key(s));
        run_cmd("random_roundtrip", scrmbl_pkg::CmdEncrypt, scrmbl_pkg::key_sel_t'(s),
                plain, 1'b0, cipher);
        compare_block("random_roundtrip", "ciphertext", cipher_exp, cipher);
        // the ciphertext from the engine goes straight back in
        run_cmd("random_roundtrip", scrmbl_pkg::CmdDecrypt, scrmbl_pkg::key_sel_t'(s),
                cipher, 1'b0, result);
        compare_block("random_roundtrip", "plaintext vs model",
                      ref_decrypt(cipher, ref_key(s)), result);
        compare_block("random_roundtrip", "plaintext vs original", plain, result);
      end
    end
    finish_test("random_roundtrip", errors_before);
  endtask

  task automatic test_busy_ignore();
    int errors_before;
    scrmbl_pkg::block_t blk;
    scrmbl_pkg::block_t result;
    errors_before = error_count;
    blk = {$random(seed), $random(seed)};
    run_cmd("busy_ignore", scrmbl_pkg::CmdEncrypt, 2'd1, blk, 1'b1, result);
    compare_block("busy_ignore", "encrypt key 1", ref_encrypt(blk, ref_key(1)), result);
    blk = {$random(seed), $random(seed)};
    run_cmd("busy_ignore", scrmbl_pkg::CmdDecrypt, 2'd2, blk, 1'b1, result);
    compare_block("busy_ignore", "decrypt key 2", ref_decrypt(blk, ref_key(2)), result);
    blk = {$random(seed), $random(seed)};
    run_cmd("busy_ignore", scrmbl_pkg::CmdEncrypt, 2'd0, blk, 1'b1, result);
    compare_block("busy_ignore", "encrypt key 0", ref_encrypt(blk, ref_key(0)), result);
    // nothing may have been accepted from the junk
    for (int c = 0; c < 5; c++) begin
      @(posedge clk_i);
      #drive_delay;
      compare_bit("busy_ignore", "valid_o when idle", 1'b0, valid_o);
      compare_bit("busy_ignore", "ready_o when idle", 1'b1, ready_o);
      compare_block("busy_ignore", "data_o when idle", '0, data_o);
    end
    finish_test("busy_ignore", errors_before);
  endtask

  // each command goes in at the drive point of the previous valid cycle
  task automatic test_back_to_back();
    int errors_before;
    scrmbl_pkg::cmd_e   cmd;
    scrmbl_pkg::block_t blk;
    scrmbl_pkg::block_t exp;
    scrmbl_pkg::block_t result;
    errors_before = error_count;
    for (int n = 0; n < 6; n++) begin
      blk = {$random(seed), $random(seed)};
      if (n % 2 == 0) begin
        cmd = scrmbl_pkg::CmdEncrypt;
        exp = ref_encrypt(blk, ref_key(n % 3));
      end else begin
        cmd = scrmbl_pkg::CmdDecrypt;
        exp = ref_decrypt(blk, ref_key(n % 3));
      end
      run_cmd("back_to_back", cmd, scrmbl_pkg::key_sel_t'(n % 3), blk, 1'b0, result);
      compare_block("back_to_back", "result", exp, result);
    end
    finish_test("back_to_back", errors_before);
  endtask

  task automatic test_escalation();
    int errors_before;
    scrmbl_pkg::block_t blk;
    scrmbl_pkg::block_t result;
    errors_before = error_count;
    blk = {$random(seed), $random(seed)};
    issue_cmd("escalation", scrmbl_pkg::CmdEncrypt, 2'd1, blk);
    repeat (12) begin
      @(posedge clk_i);
      #drive_delay;
    end
    escalate_i = 1'b1;
    @(posedge clk_i);
    #drive_delay;
    check_error_hold("escalation", 40);
    // released escalation must not clear the error, and new commands stay ignored
    escalate_i = 1'b0;
    valid_i    = 1'b1;
    cmd_i      = scrmbl_pkg::CmdEncrypt;
    sel_i      = 2'd0;
    check_error_hold("escalation", 40);
    valid_i = 1'b0;
    apply_reset();
    compare_bit("escalation", "ready_o after reset", 1'b1, ready_o);
    compare_bit("escalation", "fsm_err_o after reset", 1'b0, fsm_err_o);
    blk = {$random(seed), $random(seed)};
    run_cmd("escalation", scrmbl_pkg::CmdEncrypt, 2'd2, blk, 1'b0, result);
    compare_block("escalation", "result after reset", ref_encrypt(blk, ref_key(2)), result);
    finish_test("escalation", errors_before);
  endtask

  ////////////////////
  // sequence
  ////////////////////

  initial begin
    rst_ni     = 1'b0;
    cmd_i      = scrmbl_pkg::CmdEncrypt;
    sel_i      = '0;
    data_i     = '0;
    valid_i    = 1'b0;
    escalate_i = 1'b0;
    apply_reset();
    test_reset_values();
    test_known_vector();
    test_random_roundtrip();
    test_busy_ignore();
    test_back_to_back();
    test_escalation();
    $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
             error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+.
scrmbl_pkg.sv
scrmbl_key_lut.sv
present_enc_round.sv
present_dec_round.sv
scrmbl_datapath.sv
scrmbl_ctrl.sv
otp_scrmbl.sv
tb_otp_scrmbl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log for the pass line
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_otp_scrmbl \
    -o sim_otp_scrmbl \
  && ./obj_dir/sim_otp_scrmbl | tee sim.log \
  || { echo "build or simulation run failed"; exit 1; }

grep -q "TESTS PASSED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
